/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

    // major opcode, instruction bits [6:2]
    typedef enum logic [4:0] {
        op_load   = 5'b00000,
        op_misc   = 5'b00011,
        op_opimm  = 5'b00100,
        op_auipc  = 5'b00101,
        op_store  = 5'b01000,
        op_op     = 5'b01100,
        op_lui    = 5'b01101,
        op_branch = 5'b11000,
        op_jalr   = 5'b11001,
        op_jal    = 5'b11011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        st_reset, st_fetch, st_decode, st_exec, st_mem
    } state_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [reg_addr_w-1:0]  rd;
        logic [reg_addr_w-1:0]  rs1;
        logic [reg_addr_w-1:0]  rs2;
        logic [2:0]             funct3;
        logic [xlen-1:0]        imm;
        alu_op_t                alu_op;
        logic                   branch;
        logic                   jump;
    } decoded_t;

endpackage

`default_nettype wire

/* verilog/mem_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mem_if;
    import rv_pkg::*;

    logic            start;
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] rdata;
    logic            done;

    modport requester (output start, we, addr, wdata, input rdata, done);
    modport bus (input start, we, addr, wdata, output rdata, done);

endinterface

`default_nettype wire

/* verilog/rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_load,
    input  logic [rv_pkg::xlen-1:0]  instr,
    output rv_pkg::decoded_t         dec
);
    import rv_pkg::*;

    logic [xlen-1:0] ir;
    logic [xlen-1:0] imm_i;

    // reset leaves an addi x0,x0,0 in the instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= 32'h0000_0013;
        end else if (instr_load) begin
            ir <= instr;
        end
    end

    assign imm_i = {{20{ir[31]}}, ir[31:20]};

    always_comb begin
        dec.opcode = opcode_t'(ir[6:2]);
        dec.rd     = ir[11:7];
        dec.rs1    = ir[19:15];
        dec.rs2    = ir[24:20];
        dec.funct3 = ir[14:12];
        dec.branch = (dec.opcode == op_branch);
        dec.jump   = (dec.opcode == op_jal) || (dec.opcode == op_jalr);

        case (dec.opcode)
            op_store:  dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            op_branch: dec.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            op_lui,
            op_auipc:  dec.imm = {ir[31:12], 12'b0};
            op_jal:    dec.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:   dec.imm = imm_i;
        endcase

        // everything that is not OP or OP-IMM adds
        dec.alu_op = alu_add;
        if (dec.opcode == op_op || dec.opcode == op_opimm) begin
            case (dec.funct3)
                3'b000:  dec.alu_op = (dec.opcode == op_op && ir[30]) ? alu_sub : alu_add;
                3'b001:  dec.alu_op = alu_sll;
                3'b010:  dec.alu_op = alu_slt;
                3'b011:  dec.alu_op = alu_sltu;
                3'b100:  dec.alu_op = alu_xor;
                // funct7 bit 5, same bit as imm bit 10 of a shift immediate
                3'b101:  dec.alu_op = ir[30] ? alu_sra : alu_srl;
                3'b110:  dec.alu_op = alu_or;
                default: dec.alu_op = alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic                           clk,
    input  logic                           we,
    input  logic [rv_pkg::reg_addr_w-1:0]  rd,
    input  logic [rv_pkg::reg_addr_w-1:0]  rs1,
    input  logic [rv_pkg::reg_addr_w-1:0]  rs2,
    input  logic [rv_pkg::xlen-1:0]        wdata,
    output logic [rv_pkg::xlen-1:0]        rs1_val,
    output logic [rv_pkg::xlen-1:0]        rs2_val
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [0:(1 << reg_addr_w)-1];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rv_pc.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_pc (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pc_advance,
    input  logic                     pc_jump,
    input  logic [rv_pkg::xlen-1:0]  target,
    output logic [rv_pkg::xlen-1:0]  pc,
    output logic [rv_pkg::xlen-1:0]  pc_plus4
);
    import rv_pkg::*;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (pc_jump) begin
            // bit 0 of a jump target is always dropped
            pc <= {target[xlen-1:1], 1'b0};
        end else if (pc_advance) begin
            pc <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    input  rv_pkg::decoded_t         dec,
    input  logic [rv_pkg::xlen-1:0]  pc,
    input  logic [rv_pkg::xlen-1:0]  pc_plus4,
    input  logic [rv_pkg::xlen-1:0]  rs1_val,
    input  logic [rv_pkg::xlen-1:0]  rs2_val,
    input  logic [rv_pkg::xlen-1:0]  load_data,
    input  logic                     wb_from_load,
    output logic [rv_pkg::xlen-1:0]  alu_result,
    output logic                     take_branch,
    output logic [rv_pkg::xlen-1:0]  target,
    output logic [rv_pkg::xlen-1:0]  wdata
);
    import rv_pkg::*;

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [4:0]      shamt;
    logic            eq;
    logic            lt;
    logic            ltu;

    // pc-relative forms take the pc as first operand
    assign op1 = (dec.opcode == op_auipc || dec.opcode == op_jal || dec.branch) ? pc : rs1_val;
    assign op2 = (dec.opcode == op_op) ? rs2_val : dec.imm;
    assign shamt = op2[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_sub:  alu_result = op1 - op2;
            alu_sll:  alu_result = op1 << shamt;
            alu_slt:  alu_result = {31'b0, $signed(op1) < $signed(op2)};
            alu_sltu: alu_result = {31'b0, op1 < op2};
            alu_xor:  alu_result = op1 ^ op2;
            alu_srl:  alu_result = op1 >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op1) >>> shamt);
            alu_or:   alu_result = op1 | op2;
            alu_and:  alu_result = op1 & op2;
            default:  alu_result = op1 + op2;
        endcase
    end

    // jumps and branches add, so the sum is pc+imm or rs1+imm for jalr
    assign target = alu_result;

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    always_comb begin
        case (dec.funct3)
            3'b000:  take_branch = eq;
            3'b001:  take_branch = !eq;
            3'b100:  take_branch = lt;
            3'b101:  take_branch = !lt;
            3'b110:  take_branch = ltu;
            3'b111:  take_branch = !ltu;
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        if (wb_from_load) begin
            wdata = load_data;
        end else if (dec.opcode == op_lui) begin
            wdata = dec.imm;
        end else if (dec.jump) begin
            // link address
            wdata = pc_plus4;
        end else begin
            wdata = alu_result;
        end
    end

endmodule

`default_nettype wire

/* verilog/wb_master.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_master (
    input  logic                     clk,
    input  logic                     reset,
    mem_if.bus                       mem,
    input  logic                     wb_ack,
    input  logic [rv_pkg::xlen-1:0]  wb_dat_rd,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [rv_pkg::xlen-1:0]  wb_adr,
    output logic [rv_pkg::xlen-1:0]  wb_dat_wr
);

    // control side of the bus cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (wb_cyc && wb_ack) begin
                wb_cyc   <= 1'b0;
                wb_stb   <= 1'b0;
                wb_we    <= 1'b0;
                mem.done <= 1'b1;
            end else if (mem.start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= mem.we;
            end
        end
    end

    // address and data held for the whole cycle
    always_ff @(posedge clk) begin
        if (mem.start && !wb_cyc) begin
            wb_adr    <= mem.addr;
            wb_dat_wr <= mem.wdata;
        end
        if (wb_cyc && wb_ack) begin
            mem.rdata <= wb_dat_rd;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_control.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_control (
    input  logic                     clk,
    input  logic                     reset,
    input  rv_pkg::decoded_t         dec,
    input  logic [rv_pkg::xlen-1:0]  pc,
    input  logic [rv_pkg::xlen-1:0]  alu_result,
    input  logic [rv_pkg::xlen-1:0]  rs2_val,
    input  logic                     take_branch,
    mem_if.requester                 mem,
    output logic                     instr_load,
    output logic                     pc_advance,
    output logic                     pc_jump,
    output logic                     reg_we,
    output logic                     wb_from_load
);
    import rv_pkg::*;

    state_t state;
    logic   pending;
    logic   is_mem;
    logic   is_load;
    logic   writes_rd;
    logic   redirect;

    assign is_load  = (dec.opcode == op_load);
    assign is_mem   = is_load || (dec.opcode == op_store);
    assign redirect = dec.jump || (dec.branch && take_branch);

    always_comb begin
        case (dec.opcode)
            op_op, op_opimm, op_lui, op_auipc, op_jal, op_jalr: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // one request per fetch or mem state, issued in its first cycle
    assign mem.start = (state == st_fetch || state == st_mem) && !pending;
    assign mem.we    = (state == st_mem) && (dec.opcode == op_store);
    assign mem.addr  = (state == st_mem) ? alu_result : pc;
    assign mem.wdata = rs2_val;

    assign instr_load   = (state == st_fetch) && mem.done;
    assign wb_from_load = (state == st_mem);

    always_comb begin
        pc_advance = 1'b0;
        pc_jump    = 1'b0;
        reg_we     = 1'b0;
        case (state)
            st_exec: begin
                reg_we     = writes_rd;
                pc_jump    = redirect;
                pc_advance = !redirect && !is_mem;
            end
            st_mem: begin
                reg_we     = mem.done && is_load;
                pc_advance = mem.done;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_reset;
            pending <= 1'b0;
        end else begin
            if (mem.start) begin
                pending <= 1'b1;
            end else if (mem.done) begin
                pending <= 1'b0;
            end

            case (state)
                st_reset:  state <= st_fetch;
                st_fetch:  if (mem.done) state <= st_decode;
                st_decode: state <= st_exec;
                st_exec:   state <= is_mem ? st_mem : st_fetch;
                st_mem:    if (mem.done) state <= st_fetch;
                default:   state <= st_reset;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic         clk,
    input  logic         reset,
    input  logic         wb_ack,
    input  logic [31:0]  wb_dat_rd,
    output logic         wb_cyc,
    output logic         wb_stb,
    output logic         wb_we,
    output logic [31:0]  wb_adr,
    output logic [31:0]  wb_dat_wr
);
    import rv_pkg::*;

    decoded_t        dec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] target;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] wdata;
    logic            take_branch;
    logic            instr_load;
    logic            pc_advance;
    logic            pc_jump;
    logic            reg_we;
    logic            wb_from_load;

    mem_if mem_bus ();

    rv_control i_control (
        .clk(clk), .reset(reset), .dec(dec), .pc(pc), .alu_result(alu_result),
        .rs2_val(rs2_val), .take_branch(take_branch), .mem(mem_bus),
        .instr_load(instr_load), .pc_advance(pc_advance), .pc_jump(pc_jump),
        .reg_we(reg_we), .wb_from_load(wb_from_load)
    );

    rv_pc i_pc (
        .clk(clk), .reset(reset), .pc_advance(pc_advance), .pc_jump(pc_jump),
        .target(target), .pc(pc), .pc_plus4(pc_plus4)
    );

    // the fetched word and load data share the read data path
    rv_decoder i_decoder (
        .clk(clk), .reset(reset), .instr_load(instr_load),
        .instr(mem_bus.rdata), .dec(dec)
    );

    rv_regfile i_regfile (
        .clk(clk), .we(reg_we), .rd(dec.rd), .rs1(dec.rs1), .rs2(dec.rs2),
        .wdata(wdata), .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    rv_execute i_execute (
        .dec(dec), .pc(pc), .pc_plus4(pc_plus4), .rs1_val(rs1_val),
        .rs2_val(rs2_val), .load_data(mem_bus.rdata), .wb_from_load(wb_from_load),
        .alu_result(alu_result), .take_branch(take_branch), .target(target),
        .wdata(wdata)
    );

    wb_master i_wb_master (
        .clk(clk), .reset(reset), .mem(mem_bus), .wb_ack(wb_ack),
        .wb_dat_rd(wb_dat_rd), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_wr(wb_dat_wr)
    );

endmodule

`default_nettype wire

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam int golden_len = 67;
    localparam int mem_words = 256;
    localparam int reset_cycles = 4;
    localparam logic [31:0] marker_addr = 32'h0000_03FC;

    logic        clk;
    logic        reset;
    logic        wb_ack;
    logic [31:0] wb_dat_rd;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_wr;

    logic [31:0] golden [0:golden_len-1];
    logic [31:0] mem [0:mem_words-1];

    int          prog_words;
    int          num_instr;
    int          num_stores;
    int          rec_base;
    int          cycle_count;
    int          cycle_limit;
    int          store_idx;
    int          bus_cycles;
    int          value_errors;
    int          bus_errors;
    int          other_errors;
    int          wait_left;
    logic        in_cycle;
    logic        marker_seen;
    logic [31:0] held_adr;
    logic [31:0] held_dat;
    logic        held_we;

    rv_core i_dut (
        .clk(clk), .reset(reset), .wb_ack(wb_ack), .wb_dat_rd(wb_dat_rd),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_wr(wb_dat_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_program();
        int i;
        // unused words carry their own index
        for (i = 0; i < mem_words; i++) begin
            mem[i] = 32'hBAD0_0000 | i;
        end
        for (i = 0; i < prog_words; i++) begin
            mem[i] = golden[3 + i];
        end
    endtask

    task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] exp_adr;
        logic [31:0] exp_dat;
        if (store_idx >= num_stores) begin
            value_errors++;
            $display("** Error at %0t: extra store of %h to %h", $time, dat, adr);
        end else begin
            exp_adr = golden[rec_base + 2 * store_idx];
            exp_dat = golden[rec_base + 2 * store_idx + 1];
            if (adr !== exp_adr || dat !== exp_dat) begin
                value_errors++;
                $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, store_idx, dat, adr, exp_dat, exp_adr);
            end
        end
        store_idx++;
        if (adr == marker_addr) begin
            marker_seen = 1'b1;
        end
    endtask

    task automatic open_bus_cycle();
        in_cycle  = 1'b1;
        held_adr  = wb_adr;
        held_dat  = wb_dat_wr;
        held_we   = wb_we;
        wait_left = $urandom % 4;
        if (bus_cycles == 0 && (wb_we !== 1'b0 || wb_adr !== 32'h0)) begin
            bus_errors++;
            $display("** Error at %0t: first bus cycle is not a read of address 0", $time);
        end
        if (wb_adr[31:10] != '0 || wb_adr[1:0] != 2'b00) begin
            bus_errors++;
            $display("** Error at %0t: bus address %h outside the memory", $time, wb_adr);
        end
    endtask

    task automatic check_held_signals();
        if (wb_adr !== held_adr || wb_we !== held_we || wb_dat_wr !== held_dat) begin
            bus_errors++;
            $display("** Error at %0t: address, data or we changed during a bus cycle", $time);
        end
    endtask

    task automatic finish_bus_cycle();
        logic [7:0] idx;
        idx = wb_adr[9:2];
        if (wb_we) begin
            mem[idx] = wb_dat_wr;
            check_store(wb_adr, wb_dat_wr);
        end else begin
            wb_dat_rd <= mem[idx];
        end
        wb_ack <= 1'b1;
        in_cycle = 1'b0;
        bus_cycles++;
    endtask

    // memory model, driven and checked on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            if (wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
                bus_errors++;
                $display("** Error at %0t: wb_cyc or wb_stb high during reset", $time);
            end
        end else begin
            cycle_count++;
            if (wb_cyc !== wb_stb) begin
                bus_errors++;
                $display("** Error at %0t: wb_cyc and wb_stb differ", $time);
            end
            if (wb_ack) begin
                // cycle closed on the last rising edge
                wb_ack <= 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!in_cycle) begin
                    open_bus_cycle();
                end else begin
                    check_held_signals();
                end
                if (wait_left == 0) begin
                    finish_bus_cycle();
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        void'($urandom(42766));
        reset = 1'b1;
        wb_ack = 1'b0;
        wb_dat_rd = '0;
        cycle_count = 0;
        cycle_limit = 0;
        store_idx = 0;
        bus_cycles = 0;
        value_errors = 0;
        bus_errors = 0;
        other_errors = 0;
        wait_left = 0;
        in_cycle = 1'b0;
        marker_seen = 1'b0;
        held_adr = '0;
        held_dat = '0;
        held_we = 1'b0;

        $readmemh("tests/rv_golden.txt", golden);
        prog_words = golden[0];
        num_instr  = golden[1];
        num_stores = golden[2];
        rec_base   = 3 + prog_words;

        if ($isunknown(golden[golden_len-1]) || rec_base + 2 * num_stores != golden_len) begin
            other_errors++;
            $display("golden file is missing or its header does not match its length");
        end else begin
            load_program();
            // worst case per instruction with three wait states on each bus cycle
            cycle_limit = num_instr * 21 + 10;
            repeat (reset_cycles) @(negedge clk);
            reset <= 1'b0;
            while (!marker_seen && cycle_count < cycle_limit) begin
                @(posedge clk);
            end
            if (!marker_seen) begin
                other_errors++;
                $display("timeout: no marker store within %0d cycles", cycle_limit);
            end else if (store_idx < num_stores) begin
                other_errors++;
                $display("missing stores: marker came after %0d of %0d records",
                         store_idx, num_stores);
            end
        end

        $display("errors: %0d value, %0d bus, %0d other", value_errors, bus_errors, other_errors);
        if (value_errors + bus_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/rv_pkg.sv
verilog/mem_if.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_pc.sv
verilog/rv_execute.sv
verilog/wb_master.sv
verilog/rv_control.sv
verilog/rv_core.sv
tests/rv_core_tb.sv

/* tests/rv_golden.txt */
// header: program word count, executed instruction count, store record count
// then program words from address 0, then store records as address and data
0000002A 0000002A 0000000B
800000B7 FFB00113 401101B3 4040D213 // 00: lui x1, addi x2 -5, sub x3, srai x4
0020A2B3 00113333 00210033 003243B3 // 10: slt x5, sltu x6, add x0, xor x7
20302023 20702223 00429413 00646433 // 20: sw x3, sw x7, slli x8, or x8
20802423 20002623 00001497 0050D533 // 30: sw x8, sw x0, auipc x9, srl x10
07F17593 00B50633 20902823 20C02A23 // 40: andi x11, add x12, sw x9, sw x12
20002683 00568693 20D02C23 00000713 // 50: lw x13, addi x13, sw x13, addi x14 0
00300793 00170713 FEF71EE3 00070463 // 60: addi x15 3, loop addi, bne, beq not taken
00115463 06470713 0020E463 06470713 // 70: bge taken, skipped, bltu taken, skipped
20E02E23 00C0086F 23102023 0100006F // 80: sw x14, jal x16, sw x17, jal x0
23002223 000808E7 06470713 C0FFE937 // 90: sw x16, jalr x17, never reached, lui x18
3F202E23 0000006F                   // a0: marker store, jal to itself
00000200 7FFFFFFB // sub of min from -5
00000204 87FFFFFB // srai result xor sub result
00000208 00000010 // slt then sltu folded in
0000020C 00000000 // x0 after a write to it
00000210 00001038 // auipc at 0x38
00000214 4000007B // srl plus andi
00000218 80000000 // lw round trip plus 5
0000021C 00000003 // loop count
00000224 00000088 // jal link
00000220 00000098 // jalr link
000003FC C0FFE000 // marker
